// File: compile.f
logic/aLawPkg.sv
logic/wbSampleRegs.sv
logic/segmentFinder.sv
logic/codeFormatter.sv
logic/aLawTop.sv
test/clockGen.sv
test/aLawTb.sv

// File: logic/aLawPkg.sv
package aLawPkg;

	// Sample and code widths
	localparam int sampleWidth   = 24;
	localparam int segmentWidth  = 5;
	localparam int mantissaWidth = 8;
	localparam int codeWidth     = 15;

	// Segment clamp and mantissa cap
	localparam int maxSegment  = 18;
	localparam int mantissaMax = 255;

	// Wishbone widths
	localparam int busDataWidth = 32;
	localparam int busAddrWidth = 2;

	typedef logic [sampleWidth-1:0]   sample_t;
	typedef logic [sampleWidth-1:0]   magnitude_t;
	typedef logic [segmentWidth-1:0]  segment_t;
	typedef logic [mantissaWidth-1:0] mantissa_t;
	typedef logic [codeWidth-1:0]     code_t;
	typedef logic [busDataWidth-1:0]  busData_t;
	typedef logic [busAddrWidth-1:0]  busAddr_t;

	// Register map with addresses 2 and 3 unmapped
	localparam busAddr_t addrSample = 2'd0;
	localparam busAddr_t addrCode   = 2'd1;

	// Master to slave
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		busAddr_t adr;
		busData_t dat;
	} wbReq_t;

	// Slave to master
	typedef struct packed {
		logic     ack;
		busData_t dat;
	} wbRsp_t;

	// Stage 1 result handed to stage 2
	typedef struct packed {
		logic       valid;
		logic       negative;
		magnitude_t magnitude;
		segment_t   segment;
	} segmentInfo_t;

endpackage

// File: logic/aLawTop.sv
`timescale 1ns/1ps

module aLawTop (
	input  logic            clk,
	input  logic            rstN,
	input  aLawPkg::wbReq_t wbReq,
	output aLawPkg::wbRsp_t wbRsp
);

	// Register block to stage 1
	logic                  launch;
	aLawPkg::sample_t      sample;

	// Stage 1 to stage 2
	aLawPkg::segmentInfo_t segInfo;

	// Stage 2 back to the register block
	logic                  codeValid;
	aLawPkg::code_t        code;

	wbSampleRegs wbSampleRegs_inst (
		.clk       (clk),
		.rstN      (rstN),
		.wbReq     (wbReq),
		.wbRsp     (wbRsp),
		.launch    (launch),
		.sample    (sample),
		.codeValid (codeValid),
		.code      (code)
	);

	segmentFinder segmentFinder_inst (
		.clk     (clk),
		.rstN    (rstN),
		.launch  (launch),
		.sample  (sample),
		.segInfo (segInfo)
	);

	codeFormatter codeFormatter_inst (
		.clk       (clk),
		.rstN      (rstN),
		.segInfo   (segInfo),
		.codeValid (codeValid),
		.code      (code)
	);

endmodule

// File: logic/codeFormatter.sv
`timescale 1ns/1ps

module codeFormatter (
	input  logic                  clk,
	input  logic                  rstN,
	input  aLawPkg::segmentInfo_t segInfo,
	output logic                  codeValid,
	output aLawPkg::code_t        code
);

	// Zero-extended segment field of the code word
	localparam int segFieldWidth = aLawPkg::codeWidth - aLawPkg::mantissaWidth;

	aLawPkg::magnitude_t       offset;
	aLawPkg::magnitude_t       excess;
	aLawPkg::segment_t         stepExp;
	aLawPkg::magnitude_t       steps;
	aLawPkg::mantissa_t        mantissa;
	logic [segFieldWidth-1:0]  segField;
	aLawPkg::code_t            codeWord;
	aLawPkg::code_t            signedCode;

	logic                      codeValidQ;
	aLawPkg::code_t            codeQ;

	// Segment k starts at 16 * 2^k
	assign offset = aLawPkg::magnitude_t'(16) << segInfo.segment;

	// Nothing counts below the segment start
	assign excess = (segInfo.magnitude >= offset) ? (segInfo.magnitude - offset) : '0;

	// Segment 0 shares the step of segment 1
	assign stepExp = (segInfo.segment == '0) ? aLawPkg::segment_t'(1) : segInfo.segment;

	assign steps = excess >> stepExp;

	always_comb begin
		if (steps > aLawPkg::magnitude_t'(aLawPkg::mantissaMax)) begin
			mantissa = aLawPkg::mantissa_t'(aLawPkg::mantissaMax);
		end else begin
			mantissa = steps[aLawPkg::mantissaWidth-1:0];
		end
	end

	assign segField = segFieldWidth'(segInfo.segment);
	assign codeWord = {mantissa, segField};

	// Negative samples carry the two's complement of the whole word
	assign signedCode = segInfo.negative ? aLawPkg::code_t'(-codeWord) : codeWord;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			codeValidQ <= 1'b0;
		end else begin
			codeValidQ <= segInfo.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (segInfo.valid) begin
			codeQ <= signedCode;
		end
	end

	assign codeValid = codeValidQ;
	assign code      = codeQ;

endmodule

// File: logic/segmentFinder.sv
`timescale 1ns/1ps

module segmentFinder (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  launch,
	input  aLawPkg::sample_t      sample,
	output aLawPkg::segmentInfo_t segInfo
);

	// Lowest magnitude bit that moves a sample out of segment 0
	localparam int firstSegBit = 5;

	logic                 negative;
	aLawPkg::magnitude_t  magnitude;
	aLawPkg::segment_t    segment;

	logic                 validQ;
	logic                 negativeQ;
	aLawPkg::magnitude_t  magnitudeQ;
	aLawPkg::segment_t    segmentQ;

	// Zero counts as positive
	assign negative  = sample[aLawPkg::sampleWidth-1];
	assign magnitude = negative ? aLawPkg::magnitude_t'(-sample) : aLawPkg::magnitude_t'(sample);

	// Segment follows the highest set bit with bit 5 giving segment 1
	always_comb begin
		segment = '0;
		for (int i = firstSegBit; i < aLawPkg::sampleWidth; i++) begin
			if (magnitude[i]) begin
				segment = aLawPkg::segment_t'(i - firstSegBit + 1);
			end
		end
		// Only -2^23 reaches past the last segment
		if (segment > aLawPkg::segment_t'(aLawPkg::maxSegment)) begin
			segment = aLawPkg::segment_t'(aLawPkg::maxSegment);
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= launch;
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			negativeQ  <= negative;
			magnitudeQ <= magnitude;
			segmentQ   <= segment;
		end
	end

	always_comb begin
		segInfo.valid     = validQ;
		segInfo.negative  = negativeQ;
		segInfo.magnitude = magnitudeQ;
		segInfo.segment   = segmentQ;
	end

endmodule

// File: logic/wbSampleRegs.sv
`timescale 1ns/1ps

module wbSampleRegs (
	input  logic             clk,
	input  logic             rstN,
	input  aLawPkg::wbReq_t  wbReq,
	output aLawPkg::wbRsp_t  wbRsp,
	output logic             launch,
	output aLawPkg::sample_t sample,
	input  logic             codeValid,
	input  aLawPkg::code_t   code
);

	logic              ackQ;
	logic              launchQ;
	aLawPkg::busData_t rdDataQ;
	aLawPkg::sample_t  sampleQ;
	aLawPkg::code_t    codeQ;
	logic [1:0]        pendingCount;

	logic              request;
	logic              codeRead;
	logic              ackNext;
	logic              launchNext;
	aLawPkg::busData_t rdDataNext;

	// A transfer counts as new until its ack has been given
	assign request  = wbReq.cyc && wbReq.stb && !ackQ;
	assign codeRead = request && !wbReq.we && (wbReq.adr == aLawPkg::addrCode);

	// Code reads are held off while samples are still in the pipeline
	assign ackNext    = request && (!codeRead || (pendingCount == 2'd0));
	assign launchNext = request && wbReq.we && (wbReq.adr == aLawPkg::addrSample);

	always_comb begin
		rdDataNext = '0;
		if (!wbReq.we) begin
			case (wbReq.adr)
				aLawPkg::addrSample: rdDataNext = aLawPkg::busData_t'(sampleQ);
				aLawPkg::addrCode:   rdDataNext = aLawPkg::busData_t'(codeQ);
				default:             rdDataNext = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ackQ    <= 1'b0;
			launchQ <= 1'b0;
		end else begin
			ackQ    <= ackNext;
			launchQ <= launchNext;
		end
	end

	// Read data is latched with the ack
	always_ff @(posedge clk) begin
		if (ackNext) begin
			rdDataQ <= rdDataNext;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sampleQ <= '0;
		end else if (launchNext) begin
			sampleQ <= wbReq.dat[aLawPkg::sampleWidth-1:0];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			codeQ <= '0;
		end else if (codeValid) begin
			codeQ <= code;
		end
	end

	// Items in flight count up on launch and down on each finished code
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pendingCount <= 2'd0;
		end else begin
			case ({launchNext, codeValid})
				2'b10:   pendingCount <= pendingCount + 2'd1;
				2'b01:   pendingCount <= pendingCount - 2'd1;
				default: pendingCount <= pendingCount;
			endcase
		end
	end

	always_comb begin
		wbRsp.ack = ackQ;
		wbRsp.dat = rdDataQ;
	end

	assign launch = launchQ;
	assign sample = sampleQ;

endmodule

// File: test/aLawTb.sv
`timescale 1ns/1ps

module aLawTb;

	// About 290 samples at up to 8 cycles each with margin
	localparam int cycleLimit = 4000;
	localparam int ackLimit   = 16;
	localparam logic [31:0] lfsrSeed = 32'h46b43655;
	localparam int kindCode   = 0;
	localparam int kindSample = 1;
	localparam int kindData   = 2;

	logic              clk;
	logic              rstN;
	aLawPkg::wbReq_t   wbReq;
	aLawPkg::wbRsp_t   wbRsp;

	int                mismatchCount = 0;
	int                ackErrorCount = 0;
	int                cycleCount    = 0;
	logic [31:0]       lfsrState     = lfsrSeed;

	// Pending checks handed from the stimulus to the compare process
	int                kindQ[$];
	aLawPkg::busData_t expQ[$];
	aLawPkg::busData_t gotQ[$];
	string             labelQ[$];

	clockGen clockGen_inst (
		.clk  (clk),
		.rstN (rstN)
	);

	aLawTop aLawTop_inst (
		.clk   (clk),
		.rstN  (rstN),
		.wbReq (wbReq),
		.wbRsp (wbRsp)
	);

	function automatic aLawPkg::code_t expectedCode(input aLawPkg::sample_t value);
		logic           negative;
		longint         magnitude;
		int             segment;
		longint         offset;
		longint         step;
		longint         mantissa;
		aLawPkg::code_t word;
		negative  = value[aLawPkg::sampleWidth-1];
		magnitude = negative ? (longint'(1) << aLawPkg::sampleWidth) - longint'(value)
			: longint'(value);
		// Smallest segment whose top lies above the magnitude or else the clamp
		segment = aLawPkg::maxSegment;
		for (int k = aLawPkg::maxSegment; k >= 0; k--) begin
			if (magnitude < (longint'(32) << k)) begin
				segment = k;
			end
		end
		offset   = longint'(16) << segment;
		step     = (segment == 0) ? 2 : (longint'(1) << segment);
		mantissa = (magnitude < offset) ? 0 : (magnitude - offset) / step;
		if (mantissa > aLawPkg::mantissaMax) begin
			mantissa = aLawPkg::mantissaMax;
		end
		word = {aLawPkg::mantissa_t'(mantissa), 7'(segment)};
		if (negative) begin
			word = -word;
		end
		return word;
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic randomSample(output aLawPkg::sample_t value);
		value = '0;
		for (int i = 0; i < aLawPkg::sampleWidth; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[aLawPkg::sampleWidth-2:0], lfsrState[0]};
		end
	endtask

	task automatic checkCode(input aLawPkg::code_t expected, input aLawPkg::code_t actual,
			input string label);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, label, expected, actual);
		end
	endtask

	task automatic checkSample(input aLawPkg::sample_t expected,
			input aLawPkg::sample_t actual, input string label);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, label, expected, actual);
		end
	endtask

	task automatic checkBusData(input aLawPkg::busData_t expected,
			input aLawPkg::busData_t actual, input string label);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, label, expected, actual);
		end
	endtask

	task automatic queueCheck(input int kind, input aLawPkg::busData_t expected,
			input aLawPkg::busData_t actual, input string label);
		kindQ.push_back(kind);
		expQ.push_back(expected);
		gotQ.push_back(actual);
		labelQ.push_back(label);
	endtask

	// Ack is sampled as it stood before the edge
	task automatic busTransfer(input logic write, input aLawPkg::busAddr_t adr,
			input aLawPkg::busData_t wdat, output aLawPkg::busData_t rdat);
		aLawPkg::wbReq_t req;
		int              waited;
		logic            acked;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = write;
		req.adr = adr;
		req.dat = wdat;
		@(posedge clk);
		wbReq <= req;
		waited = 0;
		acked  = 1'b0;
		while (!acked && waited < ackLimit) begin
			@(posedge clk);
			waited++;
			acked = wbRsp.ack;
		end
		rdat = wbRsp.dat;
		wbReq <= '0;
		if (!acked) begin
			ackErrorCount++;
			$display("Error at %0t: no ack within %0d cycles for %s at address %0d",
				$time, ackLimit, write ? "write" : "read", adr);
		end
	endtask

	task automatic busWrite(input aLawPkg::busAddr_t adr, input aLawPkg::busData_t wdat);
		aLawPkg::busData_t unused;
		busTransfer(1'b1, adr, wdat, unused);
	endtask

	task automatic busRead(input aLawPkg::busAddr_t adr, output aLawPkg::busData_t rdat);
		busTransfer(1'b0, adr, '0, rdat);
	endtask

	task automatic encodeSample(input aLawPkg::sample_t value);
		aLawPkg::busData_t rdat;
		busWrite(aLawPkg::addrSample, aLawPkg::busData_t'(value));
		busRead(aLawPkg::addrCode, rdat);
		queueCheck(kindCode, aLawPkg::busData_t'(expectedCode(value)), rdat,
			$sformatf("code of sample %h", value));
	endtask

	// Register reads are zero-extended, so the bits above each field must be zero
	initial begin : compareResults
		int                kind;
		aLawPkg::busData_t expected;
		aLawPkg::busData_t actual;
		string             label;
		forever begin
			@(posedge clk);
			while (kindQ.size() > 0) begin
				kind     = kindQ.pop_front();
				expected = expQ.pop_front();
				actual   = gotQ.pop_front();
				label    = labelQ.pop_front();
				case (kind)
					kindCode: begin
						checkCode(aLawPkg::code_t'(expected), aLawPkg::code_t'(actual),
							label);
						checkBusData('0, actual >> aLawPkg::codeWidth,
							{label, " upper bits"});
					end
					kindSample: begin
						checkSample(aLawPkg::sample_t'(expected),
							aLawPkg::sample_t'(actual), label);
						checkBusData('0, actual >> aLawPkg::sampleWidth,
							{label, " upper bits"});
					end
					default: checkBusData(expected, actual, label);
				endcase
			end
		end
	end

	initial begin : watchdog
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Errors: %0d mismatches, %0d missing acks", mismatchCount, ackErrorCount);
		$display("Testbench failed");
		$finish;
	end

	initial begin : stimulus
		aLawPkg::busData_t rdat;
		aLawPkg::sample_t  value;
		aLawPkg::sample_t  first;
		aLawPkg::sample_t  second;
		wbReq = '0;
		wait (rstN === 1'b1);
		@(posedge clk);

		busRead(aLawPkg::addrCode, rdat);
		queueCheck(kindCode, '0, rdat, "code after reset");
		busRead(aLawPkg::addrSample, rdat);
		queueCheck(kindSample, '0, rdat, "sample after reset");

		encodeSample(24'd0);
		encodeSample(24'd15);
		encodeSample(24'd16);
		encodeSample(24'd31);
		encodeSample(24'd32);
		for (int k = 0; k <= aLawPkg::maxSegment; k++) begin
			encodeSample(aLawPkg::sample_t'((32 << k) - 1));
			// 32 * 2^18 no longer fits as a positive sample
			if (k < aLawPkg::maxSegment) begin
				encodeSample(aLawPkg::sample_t'(32 << k));
			end
		end
		encodeSample(24'h7fffff);

		encodeSample(-24'sd1);
		encodeSample(-24'sd16);
		encodeSample(-24'sd32);
		for (int k = 0; k <= aLawPkg::maxSegment; k++) begin
			encodeSample(aLawPkg::sample_t'(-((32 << k) - 1)));
			encodeSample(aLawPkg::sample_t'(-(32 << k)));
		end
		encodeSample(24'h800000);

		// Second write lands while the first sample is still in the pipeline
		first  = 24'h012345;
		second = 24'hfedcba;
		busWrite(aLawPkg::addrSample, aLawPkg::busData_t'(first));
		busWrite(aLawPkg::addrSample, aLawPkg::busData_t'(second));
		busRead(aLawPkg::addrCode, rdat);
		queueCheck(kindCode, aLawPkg::busData_t'(expectedCode(second)), rdat,
			"code after back to back writes");
		busRead(aLawPkg::addrSample, rdat);
		queueCheck(kindSample, aLawPkg::busData_t'(second), rdat,
			"sample after back to back writes");

		busRead(2'd2, rdat);
		queueCheck(kindData, '0, rdat, "read of address 2");
		busRead(2'd3, rdat);
		queueCheck(kindData, '0, rdat, "read of address 3");
		busWrite(aLawPkg::addrCode, 32'h00005a5a);
		busRead(aLawPkg::addrCode, rdat);
		queueCheck(kindCode, aLawPkg::busData_t'(expectedCode(second)), rdat,
			"code after write to code register");

		for (int n = 0; n < 200; n++) begin
			randomSample(value);
			encodeSample(value);
		end

		while (kindQ.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		$display("Errors: %0d mismatches, %0d missing acks", mismatchCount, ackErrorCount);
		if (mismatchCount == 0 && ackErrorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod  = 5;
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Release on a clock edge so the first active cycle is clean
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule
